//--- rtl/l1_cache_defines.svh
// L1 data cache geometry
// word width, number of sets, block size and the start of the
// non-cacheable address range, plus the field widths derived from them

`ifndef L1_CACHE_DEFINES_SVH
`define L1_CACHE_DEFINES_SVH

`define L1_WORD_W          32
`define L1_N_SETS          16
`define L1_BLOCK_WORDS     2
`define L1_NONCACHE_BASE   32'h8000_0000

// derived widths
`define L1_BYTE_LANES      (`L1_WORD_W / 8)
`define L1_BYTE_OFF_W      $clog2(`L1_BYTE_LANES)
`define L1_SET_W           $clog2(`L1_N_SETS)
`define L1_OFF_W           $clog2(`L1_BLOCK_WORDS)
`define L1_TAG_W           (`L1_WORD_W - `L1_SET_W - `L1_OFF_W - `L1_BYTE_OFF_W)

`endif

//--- rtl/l1_cache_pkg.sv
// L1 data cache types
// address fields, the frame layout, the bus request/response bundles
// shared by the processor and memory sides, and the controller states

`include "l1_cache_defines.svh"

package l1_cache_pkg;

    typedef logic [`L1_WORD_W-1:0]     word_t;
    typedef logic [`L1_BYTE_LANES-1:0] byte_en_t;
    typedef logic [`L1_SET_W-1:0]      set_idx_t;
    typedef logic [`L1_OFF_W-1:0]      blk_off_t;
    typedef logic [`L1_TAG_W-1:0]      tag_t;

    // processor address split, msb first
    typedef struct packed {
        tag_t                       tag;
        set_idx_t                   idx;
        blk_off_t                   off;
        logic [`L1_BYTE_OFF_W-1:0]  byte_off;
    } cache_addr_t;

    typedef struct packed {
        logic                           valid;
        logic                           dirty;
        tag_t                           tag;
        word_t [`L1_BLOCK_WORDS-1:0]    data;   // indexed by block offset
    } cache_frame_t;

    // same bundle on both buses
    typedef struct packed {
        logic     ren;
        logic     wen;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } bus_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } bus_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        WRITEBACK,
        FETCH,
        FLUSH_CHECK,
        FLUSH_WB
    } ctrl_state_t;

endpackage

//--- rtl/cache_frame_store.sv
// cache frame array
// one frame per set: valid, dirty, tag and data block;
// asynchronous read, whole-frame write on the clock edge

`timescale 1ns/1ns

`include "l1_cache_defines.svh"

module cache_frame_store
    import l1_cache_pkg::*;
(
    input  logic         CLK,
    input  logic         nRST,
    input  set_idx_t     rd_idx,
    output cache_frame_t rd_frame,
    input  logic         wr_en,
    input  set_idx_t     wr_idx,
    input  cache_frame_t wr_frame
);
    cache_frame_t frames [0:`L1_N_SETS-1];

    // lookup sees the frame in the same cycle as the address
    assign rd_frame = frames[rd_idx];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            // every frame comes up invalid and clean
            for (int i = 0; i < `L1_N_SETS; i++) begin
                frames[i] <= '0;
            end
        end else if (wr_en) begin
            frames[wr_idx] <= wr_frame;     // hit merge, fill or invalidate
        end
    end

endmodule

//--- rtl/cache_lookup.sv
// cache lookup
// splits the processor address, compares the tag of the indexed frame,
// flags the non-cacheable range and prepares the byte-merged write data
// for both a write hit and an uncached write

`timescale 1ns/1ns

`include "l1_cache_defines.svh"

module cache_lookup
    import l1_cache_pkg::*;
(
    input  bus_req_t     proc_req,
    input  cache_frame_t rd_frame,
    output cache_addr_t  req_addr,
    output logic         hit,
    output logic         uncached,
    output word_t        hit_word,
    output cache_frame_t hit_wr_frame,
    output word_t        uncached_wdata
);
    word_t lane_mask;   // byte enables widened to one bit per data bit
    word_t merged_word;

    assign req_addr = cache_addr_t'(proc_req.addr);
    assign uncached = (proc_req.addr >= `L1_NONCACHE_BASE);

    // uncached addresses carry the top tag bit, so they never match a cached tag
    assign hit      = rd_frame.valid && (rd_frame.tag == req_addr.tag);
    assign hit_word = rd_frame.data[req_addr.off];

    always_comb begin
        for (int i = 0; i < `L1_BYTE_LANES; i++) begin
            lane_mask[i*8 +: 8] = {8{proc_req.byte_en[i]}};
        end
    end

    // enabled lanes take new data, the rest keep the cached bytes
    assign merged_word = (hit_word & ~lane_mask) | (proc_req.wdata & lane_mask);

    always_comb begin
        hit_wr_frame                    = rd_frame;
        hit_wr_frame.dirty              = 1'b1;
        hit_wr_frame.data[req_addr.off] = merged_word;
    end

    // memory sees zeros on lanes that are not written
    assign uncached_wdata = proc_req.wdata & lane_mask;

endmodule

//--- rtl/cache_ctrl.sv
// cache controller
// serves hits from IDLE, runs write-back and block fill on a miss,
// passes non-cacheable accesses straight to memory, and walks every
// set on flush, writing back dirty frames and invalidating the array

`timescale 1ns/1ns

`include "l1_cache_defines.svh"

module cache_ctrl
    import l1_cache_pkg::*;
(
    input  logic         CLK,
    input  logic         nRST,
    input  logic         flush,
    output logic         flush_done,
    input  bus_req_t     proc_req,
    output bus_rsp_t     proc_rsp,
    output bus_req_t     mem_req,
    input  bus_rsp_t     mem_rsp,
    input  cache_addr_t  req_addr,
    input  logic         hit,
    input  logic         uncached,
    input  word_t        hit_word,
    input  cache_frame_t hit_wr_frame,
    input  word_t        uncached_wdata,
    input  cache_frame_t rd_frame,
    output set_idx_t     rd_idx,
    output set_idx_t     wr_idx,
    output logic         wr_en,
    output cache_frame_t wr_frame
);
    // one spare bit so the fill can count past its last word
    typedef logic [`L1_OFF_W:0] word_cnt_t;

    ctrl_state_t  state, next_state;
    word_cnt_t    word_cnt, next_word_cnt;
    set_idx_t     set_cnt, next_set_cnt;
    cache_frame_t fill_frame;               // block being collected during FETCH
    blk_off_t     word_idx;
    logic         flushing;
    logic         last_word;
    logic         fill_full;
    logic         beat_done;
    logic         proc_active;
    cache_addr_t  victim_addr;
    cache_addr_t  fill_addr;

    assign word_idx    = word_cnt[`L1_OFF_W-1:0];
    assign last_word   = (word_cnt == word_cnt_t'(`L1_BLOCK_WORDS - 1));
    assign fill_full   = (word_cnt == word_cnt_t'(`L1_BLOCK_WORDS));
    assign beat_done   = ~mem_rsp.busy;
    assign proc_active = proc_req.ren || proc_req.wen;

    // flush walks the array with its own counter
    assign flushing = (state == FLUSH_CHECK) || (state == FLUSH_WB);
    assign rd_idx   = flushing ? set_cnt : req_addr.idx;
    assign wr_idx   = rd_idx;

    // victim address covers both miss write-back and flush write-back
    assign victim_addr = '{tag: rd_frame.tag, idx: rd_idx, off: word_idx, byte_off: '0};
    assign fill_addr   = '{tag: req_addr.tag, idx: req_addr.idx, off: word_idx, byte_off: '0};

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            word_cnt <= '0;
            set_cnt  <= '0;
        end else begin
            state    <= next_state;
            word_cnt <= next_word_cnt;
            set_cnt  <= next_set_cnt;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == FETCH && !fill_full && beat_done) begin
            fill_frame.valid          <= 1'b1;
            fill_frame.dirty          <= 1'b0;  // fresh from memory
            fill_frame.tag            <= req_addr.tag;
            fill_frame.data[word_idx] <= mem_rsp.rdata;
        end
    end

    always_comb begin
        next_state    = state;
        next_word_cnt = word_cnt;
        next_set_cnt  = set_cnt;
        proc_rsp      = '{busy: 1'b1, rdata: '0};
        mem_req       = '0;
        wr_en         = 1'b0;
        wr_frame      = '0;
        flush_done    = 1'b0;

        case (state)
            IDLE: begin
                if (flush) begin
                    next_state = FLUSH_CHECK;   // requests wait while flush is up
                end else if (proc_active) begin
                    if (uncached) begin
                        mem_req       = proc_req;
                        mem_req.wdata = uncached_wdata;
                        proc_rsp      = mem_rsp;
                    end else if (hit) begin
                        proc_rsp.busy = 1'b0;
                        if (proc_req.ren) begin
                            proc_rsp.rdata = hit_word;
                        end else begin
                            wr_en    = 1'b1;
                            wr_frame = hit_wr_frame;
                        end
                    end else if (rd_frame.valid && rd_frame.dirty) begin
                        next_state = WRITEBACK;
                    end else begin
                        next_state = FETCH;
                    end
                end
            end

            // both write-back flavours drive the same beats
            WRITEBACK, FLUSH_WB: begin
                mem_req.wen     = 1'b1;
                mem_req.addr    = victim_addr;
                mem_req.wdata   = rd_frame.data[word_idx];
                mem_req.byte_en = '1;
                if (beat_done) begin
                    if (last_word) begin
                        next_word_cnt = '0;
                        if (state == WRITEBACK) begin
                            next_state = FETCH;     // fill overwrites the victim
                        end else begin
                            wr_en      = 1'b1;      // wr_frame stays zero, frame invalid
                            next_state = FLUSH_CHECK;
                        end
                    end else begin
                        next_word_cnt = word_cnt + 1'b1;
                    end
                end
            end

            FETCH: begin
                if (fill_full) begin
                    wr_en         = 1'b1;
                    wr_frame      = fill_frame;
                    next_word_cnt = '0;
                    next_state    = IDLE;           // retried as a hit
                end else begin
                    mem_req.ren     = 1'b1;
                    mem_req.addr    = fill_addr;
                    mem_req.byte_en = '1;
                    if (beat_done) begin
                        next_word_cnt = word_cnt + 1'b1;
                    end
                end
            end

            FLUSH_CHECK: begin
                if (rd_frame.valid && rd_frame.dirty) begin
                    next_state = FLUSH_WB;
                end else begin
                    wr_en        = 1'b1;            // clean or empty, just invalidate
                    next_set_cnt = set_cnt + 1'b1;  // wraps back to set 0 at the end
                    if (set_cnt == set_idx_t'(`L1_N_SETS - 1)) begin
                        flush_done = 1'b1;
                        next_state = IDLE;
                    end
                end
            end

            default: next_state = IDLE;
        endcase
    end

endmodule

//--- rtl/l1_cache.sv
// L1 data cache, top level
// direct mapped, write-back, write-allocate; sits between the processor
// bus and the memory bus, with pass-through of the non-cacheable range
// and a flush that writes back and invalidates every frame

`timescale 1ns/1ns

`include "l1_cache_defines.svh"

module l1_cache
    import l1_cache_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  logic     flush,
    output logic     flush_done,
    input  bus_req_t proc_req,
    output bus_rsp_t proc_rsp,
    output bus_req_t mem_req,
    input  bus_rsp_t mem_rsp
);
    cache_addr_t  req_addr;
    logic         hit;
    logic         uncached;
    word_t        hit_word;
    cache_frame_t hit_wr_frame;
    word_t        uncached_wdata;

    // frame array ports
    set_idx_t     rd_idx;
    set_idx_t     wr_idx;
    cache_frame_t rd_frame;
    cache_frame_t wr_frame;
    logic         wr_en;

    cache_lookup u_lookup (
        .proc_req       (proc_req),
        .rd_frame       (rd_frame),
        .req_addr       (req_addr),
        .hit            (hit),
        .uncached       (uncached),
        .hit_word       (hit_word),
        .hit_wr_frame   (hit_wr_frame),
        .uncached_wdata (uncached_wdata)
    );

    cache_frame_store u_frames (
        .CLK      (CLK),
        .nRST     (nRST),
        .rd_idx   (rd_idx),
        .rd_frame (rd_frame),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_frame (wr_frame)
    );

    cache_ctrl u_ctrl (
        .CLK            (CLK),
        .nRST           (nRST),
        .flush          (flush),
        .flush_done     (flush_done),
        .proc_req       (proc_req),
        .proc_rsp       (proc_rsp),
        .mem_req        (mem_req),
        .mem_rsp        (mem_rsp),
        .req_addr       (req_addr),
        .hit            (hit),
        .uncached       (uncached),
        .hit_word       (hit_word),
        .hit_wr_frame   (hit_wr_frame),
        .uncached_wdata (uncached_wdata),
        .rd_frame       (rd_frame),
        .rd_idx         (rd_idx),
        .wr_idx         (wr_idx),
        .wr_en          (wr_en),
        .wr_frame       (wr_frame)
    );

endmodule

//--- tests/l1_cache_assert.sv
// protocol checks on the L1 cache ports
// bound into the cache top level by the testbench

`timescale 1ns/1ns

module l1_cache_assert
    import l1_cache_pkg::*;
(
    input logic     CLK,
    input logic     nRST,
    input logic     flush,
    input logic     flush_done,
    input bus_req_t mem_req,
    input bus_rsp_t mem_rsp
);
    int n_fail = 0;     // failed assertions so far

    // a memory beat is either a read or a write
    mem_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else begin
            n_fail++;
            $error("mem ren and wen high together");
        end

    flush_done_in_flush: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |-> flush)
        else begin
            n_fail++;
            $error("flush_done high while flush is low");
        end

    // a stalled beat keeps its request
    mem_req_held: assert property (@(posedge CLK) disable iff (!nRST)
        mem_rsp.busy |=> $stable(mem_req))
        else begin
            n_fail++;
            $error("mem_req changed while mem busy was high");
        end

endmodule

//--- tests/l1_cache_tb_mem.sv
// memory model for the L1 cache testbench
// word array that starts from an address-derived pattern, merges
// writes by byte lane and stalls each beat for 0 to 3 busy cycles

`timescale 1ns/1ns

`include "l1_cache_defines.svh"

module l1_cache_tb_mem
    import l1_cache_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  bus_req_t mem_req,
    output bus_rsp_t mem_rsp
);
    localparam int N_WORDS = 2048;  // 1k words from 0 and 1k words from the uncached base

    word_t       mem [0:N_WORDS-1];
    logic [31:0] lcg_state;
    logic [31:0] lcg_nxt;
    logic [1:0]  wait_left;         // busy cycles still owed to the current beat
    logic [10:0] idx;
    logic        present;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    assign lcg_nxt = lcg_step(lcg_state);
    assign idx     = {mem_req.addr[31], mem_req.addr[11:2]};
    assign present = mem_req.ren || mem_req.wen;
    assign mem_rsp = '{busy: present && (wait_left != 2'd0), rdata: mem[idx]};

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lcg_state <= 32'ha642;
            wait_left <= 2'd0;
            for (int i = 0; i < N_WORDS; i++) begin
                mem[i] <= {i[10], 19'b0, i[9:0], 2'b00} ^ 32'hA5A5A5A5;
            end
        end else if (present) begin
            if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                lcg_state <= lcg_nxt;
                wait_left <= lcg_nxt[17:16];    // stall for the next beat
                if (mem_req.wen) begin
                    for (int b = 0; b < `L1_BYTE_LANES; b++) begin
                        if (mem_req.byte_en[b]) begin
                            mem[idx][b*8 +: 8] <= mem_req.wdata[b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

//--- tests/l1_cache_tb.sv
// testbench for the L1 data cache
// applies a table of reads, writes and flushes, keeps a shadow copy of
// memory for the expected read data and counts write-back beats on flush

`timescale 1ns/1ns

`include "l1_cache_defines.svh"

module l1_cache_tb
    import l1_cache_pkg::*;
();
    localparam int N_ROWS   = 20;
    localparam int RST_CYC  = 16;
    localparam int WDOG_CYC = N_ROWS * 40 + RST_CYC;

    typedef enum logic [1:0] {OP_RD, OP_WR, OP_FLUSH} op_t;

    typedef struct packed {
        op_t      op;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
        word_t    exp;      // mem wdata of an uncached write, write beats of a flush
    } test_row_t;

    logic      CLK;
    logic      nRST;
    logic      flush;
    logic      flush_done;
    bus_req_t  proc_req;
    bus_rsp_t  proc_rsp;
    bus_req_t  mem_req;
    bus_rsp_t  mem_rsp;
    test_row_t rows [0:N_ROWS-1];
    word_t     shadow [0:2047];
    int        n_errors;
    int        n_checks;

    l1_cache u_dut (.*);
    l1_cache_tb_mem u_mem (.*);

    bind l1_cache l1_cache_assert u_assert (
        .CLK        (CLK),
        .nRST       (nRST),
        .flush      (flush),
        .flush_done (flush_done),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial begin
        repeat (WDOG_CYC) @(posedge CLK);
        $display("timeout: table not finished within %0d cycles", WDOG_CYC);
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [10:0] shadow_idx(input word_t addr);
        return {addr[31], addr[11:2]};
    endfunction

    // enabled lanes take the new byte
    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input byte_en_t be);
        word_t res;
        res = old_w;
        for (int i = 0; i < `L1_BYTE_LANES; i++) begin
            if (be[i]) begin
                res[i*8 +: 8] = new_w[i*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic string op_label(input op_t op);
        case (op)
            OP_RD:   return "read";
            OP_WR:   return "write";
            default: return "flush";
        endcase
    endfunction

    // value mismatches plus failed protocol assertions
    function automatic int error_count();
        return n_errors + u_dut.u_assert.n_fail;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("error: %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic set_row(input int i, input op_t op, input word_t addr, input word_t wdata,
                           input byte_en_t be, input word_t exp);
        rows[i] = '{op: op, addr: addr, wdata: wdata, byte_en: be, exp: exp};
    endtask

    task automatic load_table();
        set_row(0,  OP_RD,    32'h0000_0000, 32'h0,         4'hf, 32'h0);   // miss then hit
        set_row(1,  OP_RD,    32'h0000_0000, 32'h0,         4'hf, 32'h0);
        set_row(2,  OP_WR,    32'h0000_0008, 32'h1122_3344, 4'h1, 32'h0);
        set_row(3,  OP_RD,    32'h0000_0008, 32'h0,         4'hf, 32'h0);
        set_row(4,  OP_WR,    32'h0000_0008, 32'hAABB_CCDD, 4'hc, 32'h0);
        set_row(5,  OP_RD,    32'h0000_0008, 32'h0,         4'hf, 32'h0);
        set_row(6,  OP_WR,    32'h0000_0008, 32'h0102_0304, 4'hf, 32'h0);
        set_row(7,  OP_RD,    32'h0000_0008, 32'h0,         4'hf, 32'h0);
        set_row(8,  OP_WR,    32'h0000_0010, 32'hDEAD_BEEF, 4'hf, 32'h0);   // set 2, tag 0
        set_row(9,  OP_RD,    32'h0000_0090, 32'h0,         4'hf, 32'h0);   // set 2, tag 1
        set_row(10, OP_RD,    32'h0000_0010, 32'h0,         4'hf, 32'h0);
        set_row(11, OP_WR,    32'h8000_0010, 32'h1234_5678, 4'h2, 32'h0000_5600);
        set_row(12, OP_RD,    32'h8000_0010, 32'h0,         4'hf, 32'h0);
        set_row(13, OP_WR,    32'h0000_0020, 32'hCAFE_F00D, 4'hf, 32'h0);
        set_row(14, OP_WR,    32'h0000_003C, 32'h0000_BEEF, 4'h3, 32'h0);
        // sets 1, 4 and 7 are dirty at this point
        set_row(15, OP_FLUSH, 32'h0,         32'h0,         4'h0, 3 * `L1_BLOCK_WORDS);
        set_row(16, OP_RD,    32'h0000_0008, 32'h0,         4'hf, 32'h0);
        set_row(17, OP_RD,    32'h0000_0020, 32'h0,         4'hf, 32'h0);
        set_row(18, OP_RD,    32'h0000_003C, 32'h0,         4'hf, 32'h0);
        set_row(19, OP_RD,    32'h0000_0010, 32'h0,         4'hf, 32'h0);
    endtask

    // holds the request until busy is seen low at a falling edge
    task automatic proc_access(input test_row_t row, output word_t rdata,
                               output word_t mem_wdata);
        @(posedge CLK);
        #1;
        proc_req = '{ren: (row.op == OP_RD), wen: (row.op == OP_WR), addr: row.addr,
                     wdata: row.wdata, byte_en: row.byte_en};
        @(negedge CLK);
        while (proc_rsp.busy) begin
            @(negedge CLK);
        end
        rdata     = proc_rsp.rdata;
        mem_wdata = mem_req.wdata;
        @(posedge CLK);
        #1;
        proc_req = '0;
    endtask

    task automatic run_flush(output int beats);
        beats = 0;
        @(posedge CLK);
        #1;
        flush = 1'b1;
        @(negedge CLK);
        while (!flush_done) begin
            if (mem_req.wen && !mem_rsp.busy) begin
                beats++;                // one completed write-back beat
            end
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
        flush = 1'b0;
    endtask

    initial begin
        word_t       rdata;
        word_t       mem_wdata;
        logic [10:0] idx;
        int          beats;
        int          errs_before;
        nRST     = 1'b0;
        flush    = 1'b0;
        proc_req = '0;
        n_errors = 0;
        n_checks = 0;
        load_table();
        for (int a = 0; a < 2048; a++) begin
            shadow[a] = {a[10], 19'b0, a[9:0], 2'b00} ^ 32'hA5A5A5A5;
        end
        repeat (RST_CYC) @(posedge CLK);
        #1;
        nRST = 1'b1;

        for (int i = 0; i < N_ROWS; i++) begin
            errs_before = error_count();
            case (rows[i].op)
                OP_FLUSH: begin
                    run_flush(beats);
                    check_value("flush mem write beats", rows[i].exp, word_t'(beats));
                end
                OP_WR: begin
                    proc_access(rows[i], rdata, mem_wdata);
                    idx         = shadow_idx(rows[i].addr);
                    shadow[idx] = merge_bytes(shadow[idx], rows[i].wdata, rows[i].byte_en);
                    if (rows[i].addr >= `L1_NONCACHE_BASE) begin
                        check_value("mem_req.wdata", rows[i].exp, mem_wdata);
                    end
                end
                default: begin
                    proc_access(rows[i], rdata, mem_wdata);
                    check_value("proc_rsp.rdata", shadow[shadow_idx(rows[i].addr)], rdata);
                end
            endcase
            $display("test %0d %s addr %h: %s", i, op_label(rows[i].op), rows[i].addr,
                     (error_count() == errs_before) ? "ok" : "mismatch");
        end

        $display("%0d tests, %0d checks, %0d errors", N_ROWS, n_checks, error_count());
        if (error_count() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- l1_cache.f
+incdir+rtl
rtl/l1_cache_pkg.sv
rtl/cache_frame_store.sv
rtl/cache_lookup.sv
rtl/cache_ctrl.sv
rtl/l1_cache.sv
tests/l1_cache_assert.sv
tests/l1_cache_tb_mem.sv
tests/l1_cache_tb.sv
